/* corePkg.sv */
// stage payload and ALU operation types, imported by the core's pipeline modules
`include "core_config.svh"

package corePkg;

  ////////////////////////////////////////////////////////////////////////////
  // ALU operations
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,       // signed compare
    aluSltu,      // unsigned compare
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluPassImm    // lui, immediate straight through
  } aluOp_t;

  ////////////////////////////////////////////////////////////////////////////
  // stage payloads
  ////////////////////////////////////////////////////////////////////////////

  // decode -> execute
  typedef struct packed {
    logic [`CORE_REGAW-1:0] rd;
    logic [`CORE_REGAW-1:0] rs1;
    logic [`CORE_REGAW-1:0] rs2;
    logic [`CORE_XLEN-1:0]  imm;      // I-type or U-type, already formed
    logic                   immSel;   // operand b from imm, not rs2
    aluOp_t                 aluOp;
    logic                   writeEn;
    logic                   illegal;
  } decodedInstr_t;

  // execute -> writeback, also the retire record
  typedef struct packed {
    logic [`CORE_REGAW-1:0] rd;
    logic [`CORE_XLEN-1:0]  data;
    logic                   writeEn;
    logic                   illegal;
  } execResult_t;

endpackage

/* coreTb.sv */
// self-checking testbench for coreTop; run as top module coreTb with the files of vlog.f
`timescale 1ns/1ns
`include "core_config.svh"

module coreTb;

  typedef struct packed {
    logic [`CORE_REGAW-1:0] rd;
    logic [`CORE_XLEN-1:0]  data;
    logic                   illegal;
  } expRec_t;

  localparam int PRELOADS = 8;   // x1..x8

  logic                   clk;
  logic                   rstN;
  logic                   instrValid;
  logic [31:0]            instr;
  logic [`CORE_REGAW-1:0] debugRegAddr;
  logic [`CORE_XLEN-1:0]  debugRegWdata;
  logic                   debugRegWrite;
  logic                   retireValid;
  logic [`CORE_REGAW-1:0] retireRd;
  logic [`CORE_XLEN-1:0]  retireData;
  logic                   retireIllegal;
  logic [`CORE_XLEN-1:0]  debugRegRdata;

  logic [`CORE_XLEN-1:0]  model [`CORE_NREGS];   // reference register file
  logic [31:0]            tblInstr [$];
  logic                   tblGap [$];            // idle strobe cycle before the entry
  logic                   tblIllegal [$];
  expRec_t                expQ [$];
  logic [31:0]            lfsr = 32'd77489;
  int                     errors = 0;
  int                     cycleCount = 0;
  int                     limit;
  int                     drainWait;

  coreTop u_coreTop (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // taps x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] randWord();
    logic [31:0] w;
    w = '0;
    for (int k = 0; k < 32; k++) begin
      w = {w[30:0], lfsrBit()};
    end
    return w;
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `CORE_OP_REG};
  endfunction

  function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, `CORE_OP_IMM};
  endfunction

  // RV32I semantics on the model registers
  function automatic logic [31:0] refResult(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    a = model[w[19:15]];
    b = (w[6:0] == `CORE_OP_REG) ? model[w[24:20]] : {{20{w[31]}}, w[31:20]};
    if (w[6:0] == `CORE_OP_LUI) return {w[31:12], 12'h000};
    case (w[14:12])
      3'd0:    return (w[6:0] == `CORE_OP_REG && w[30]) ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return w[30] ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic addEntry(input logic [31:0] w, input logic gap, input logic ill);
    tblInstr.push_back(w);
    tblGap.push_back(gap);
    tblIllegal.push_back(ill);
  endtask

  task automatic queueExpected(input logic [31:0] w, input logic ill);
    expRec_t e;
    e.rd      = w[11:7];
    e.illegal = ill;
    e.data    = ill ? '0 : refResult(w);
    expQ.push_back(e);
    if (!ill && e.rd != '0) model[e.rd] = e.data;   // program order
  endtask

  task automatic buildTable();
    addEntry(encR(7'h00, 2, 1, 3'd0, 9), 1, 0);    // add
    addEntry(encR(7'h20, 4, 3, 3'd0, 10), 0, 0);   // sub
    addEntry(encR(7'h00, 6, 5, 3'd1, 11), 1, 0);   // sll
    addEntry(encR(7'h00, 7, 1, 3'd2, 12), 0, 0);   // slt
    addEntry(encR(7'h00, 7, 1, 3'd3, 13), 0, 0);   // sltu
    addEntry(encR(7'h00, 3, 2, 3'd4, 14), 1, 0);   // xor
    addEntry(encR(7'h00, 5, 4, 3'd5, 15), 0, 0);   // srl
    addEntry(encR(7'h20, 6, 8, 3'd5, 16), 0, 0);   // sra
    addEntry(encR(7'h00, 8, 1, 3'd6, 17), 0, 0);   // or
    addEntry(encR(7'h00, 7, 2, 3'd7, 18), 1, 0);   // and
    addEntry(encR(7'h20, 1, 0, 3'd0, 19), 0, 0);   // 0 - x1 wraps
    addEntry(encI(12'hFFB, 1, 3'd0, 20), 0, 0);    // addi -5
    addEntry(encI(12'hFFF, 2, 3'd2, 21), 1, 0);    // slti -1
    addEntry(encI(12'hFFF, 3, 3'd3, 22), 0, 0);    // sltiu with imm sign-extended to all ones
    addEntry(encI(12'h800, 4, 3'd4, 23), 0, 0);
    addEntry(encI(12'h0F0, 5, 3'd6, 24), 0, 0);
    addEntry(encI(12'hFF0, 6, 3'd7, 25), 1, 0);
    addEntry(encI(12'h01F, 7, 3'd1, 26), 0, 0);    // slli 31
    addEntry(encI(12'h011, 8, 3'd5, 27), 0, 0);    // srli 17
    addEntry(encI(12'h40D, 1, 3'd5, 28), 0, 0);    // srai 13
    addEntry({20'hABCDE, 5'd29, `CORE_OP_LUI}, 1, 0);
    // dependent chain without gaps
    addEntry(encI(12'h001, 0, 3'd0, 30), 0, 0);
    addEntry(encR(7'h00, 30, 30, 3'd0, 30), 0, 0);
    addEntry(encR(7'h00, 1, 30, 3'd0, 30), 0, 0);
    addEntry(encR(7'h20, 2, 30, 3'd0, 31), 0, 0);
    addEntry(encR(7'h00, 30, 31, 3'd4, 31), 0, 0);
    // x0 as destination and then as source
    addEntry(encR(7'h00, 2, 1, 3'd0, 0), 1, 0);
    addEntry(encR(7'h00, 3, 0, 3'd0, 9), 0, 0);
    // unsupported load opcode and a mul encoding
    addEntry({12'h000, 5'd1, 3'd2, 5'd4, 7'b0000011}, 0, 1);
    addEntry(encR(7'h01, 2, 1, 3'd0, 5), 0, 1);
    addEntry(encR(7'h00, 5, 4, 3'd0, 6), 0, 0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // retire monitor sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : retireCheck
    expRec_t e;
    if (rstN && retireValid) begin
      assert (expQ.size() != 0) else begin
        $display("retire of x%0d at %0t with no instruction outstanding", retireRd, $time);
        errors++;
      end
      if (expQ.size() != 0) begin
        e = expQ.pop_front();
        assert (retireRd == e.rd) else begin
          $display("MISMATCH t=%0t retireRd exp=%0d got=%0d", $time, e.rd, retireRd);
          errors++;
        end
        assert (retireIllegal == e.illegal) else begin
          $display("MISMATCH t=%0t retireIllegal exp=%0b got=%0b", $time, e.illegal,
                   retireIllegal);
          errors++;
        end
        assert (e.illegal || retireData == e.data) else begin
          $display("MISMATCH t=%0t retireData exp=%h got=%h", $time, e.data, retireData);
          errors++;
        end
      end
    end
  end

  // bound allows two cycles per entry plus preload, final reads, reset and drain
  initial begin : watchdog
    @(posedge clk);
    limit = 2 * tblInstr.size() + PRELOADS + `CORE_NREGS + 20;
    while (cycleCount < limit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("timeout, run still going after %0d cycles", limit);
    $display("errors: %0d", errors + 1);
    $display("TEST FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rstN          = 1'b0;
    instrValid    = 1'b0;
    instr         = '0;
    debugRegAddr  = '0;
    debugRegWdata = '0;
    debugRegWrite = 1'b0;
    for (int r = 0; r < `CORE_NREGS; r++) model[r] = '0;
    buildTable();
    repeat (3) @(posedge clk);
    rstN <= 1'b1;

    for (int r = 1; r <= PRELOADS; r++) begin   // preload via debug port
      @(posedge clk);
      model[r] = randWord();
      debugRegAddr  <= r[`CORE_REGAW-1:0];
      debugRegWdata <= model[r];
      debugRegWrite <= 1'b1;
    end
    @(posedge clk);
    debugRegWrite <= 1'b0;

    for (int i = 0; i < tblInstr.size(); i++) begin
      if (tblGap[i]) begin
        @(posedge clk);
        instrValid <= 1'b0;
      end
      @(posedge clk);
      instrValid <= 1'b1;
      instr      <= tblInstr[i];
      queueExpected(tblInstr[i], tblIllegal[i]);
    end
    @(posedge clk);
    instrValid <= 1'b0;

    drainWait = 0;
    while (expQ.size() != 0 && drainWait < 10) begin
      @(posedge clk);
      drainWait++;
    end
    assert (expQ.size() == 0) else begin
      $display("%0d instructions never retired", expQ.size());
      errors += expQ.size();
    end

    for (int r = 0; r < `CORE_NREGS; r++) begin   // final register dump
      @(posedge clk);
      debugRegAddr <= r[`CORE_REGAW-1:0];
      @(negedge clk);
      assert (debugRegRdata == model[r]) else begin
        $display("MISMATCH t=%0t debugRegRdata[x%0d] exp=%h got=%h", $time, r, model[r],
                 debugRegRdata);
        errors++;
      end
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* coreTop.sv */
// top level of the three-stage RV32I integer core, wiring decode, execute and writeback
`timescale 1ns/1ns
`include "core_config.svh"

module coreTop (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   instrValid,
  input  logic [31:0]            instr,
  input  logic [`CORE_REGAW-1:0] debugRegAddr,
  input  logic [`CORE_XLEN-1:0]  debugRegWdata,
  input  logic                   debugRegWrite,
  output logic                   retireValid,
  output logic [`CORE_REGAW-1:0] retireRd,
  output logic [`CORE_XLEN-1:0]  retireData,
  output logic                   retireIllegal,
  output logic [`CORE_XLEN-1:0]  debugRegRdata
);
  import corePkg::*;

  // decode -> execute
  logic                   decValid;
  decodedInstr_t          decInstr;
  logic                   exValid;
  decodedInstr_t          exInstr;

  // execute <-> register file
  logic [`CORE_REGAW-1:0] rs1Addr, rs2Addr;
  logic [`CORE_XLEN-1:0]  rs1Data, rs2Data;
  logic                   resValid;
  execResult_t            res;

  instrDecoder u_instrDecoder (.clk, .rstN, .instrValid, .instr, .decValid, .decInstr);

  // edge 1 boundary
  stageReg #(.payload_t(decodedInstr_t)) u_exStage (
    .clk, .rstN,
    .inValid (decValid), .inData (decInstr),
    .outValid(exValid),  .outData(exInstr)
  );

  execUnit u_execUnit (
    .exValid, .exInstr, .rs1Data, .rs2Data,
    .rs1Addr, .rs2Addr, .resValid, .res
  );

  writebackStage u_writebackStage (
    .clk, .rstN, .resValid, .res,
    .rs1Addr, .rs2Addr, .rs1Data, .rs2Data,
    .debugRegAddr, .debugRegWdata, .debugRegWrite, .debugRegRdata,
    .retireValid, .retireRd, .retireData, .retireIllegal
  );

endmodule

/* core_config.svh */
// core widths, register count and opcodes; include wherever these values are needed
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath
`define CORE_XLEN   32    // integer register and ALU width
`define CORE_NREGS  32    // x0..x31
`define CORE_REGAW  5     // register index bits

////////////////////////////////////////////////////////////////////////////
// major opcodes handled by the decoder
////////////////////////////////////////////////////////////////////////////

// register-register ALU ops
`define CORE_OP_REG 7'b0110011
// register-immediate ALU ops
`define CORE_OP_IMM 7'b0010011
// load upper immediate
`define CORE_OP_LUI 7'b0110111

// anything else decodes as illegal

`endif

/* execUnit.sv */
// execute stage: reads the source registers and computes the ALU result for writeback
`timescale 1ns/1ns
`include "core_config.svh"

module execUnit (
  input  logic                   exValid,
  input  corePkg::decodedInstr_t exInstr,
  input  logic [`CORE_XLEN-1:0]  rs1Data,
  input  logic [`CORE_XLEN-1:0]  rs2Data,
  output logic [`CORE_REGAW-1:0] rs1Addr,
  output logic [`CORE_REGAW-1:0] rs2Addr,
  output logic                   resValid,
  output corePkg::execResult_t   res
);
  import corePkg::*;

  logic [`CORE_XLEN-1:0] opA;
  logic [`CORE_XLEN-1:0] opB;
  logic [4:0]            shamt;
  logic [`CORE_XLEN-1:0] aluRes;

  ////////////////////////////////////////////////////////////////////////////
  // operand fetch
  ////////////////////////////////////////////////////////////////////////////

  // register file is read here, the writeback of the previous op is already in
  assign rs1Addr = exInstr.rs1;
  assign rs2Addr = exInstr.rs2;

  assign opA   = rs1Data;
  assign opB   = exInstr.immSel ? exInstr.imm : rs2Data;
  assign shamt = opB[4:0];   // shifts ignore the upper bits

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (exInstr.aluOp)
      aluAdd:  aluRes = opA + opB;
      aluSub:  aluRes = opA - opB;   // wraps
      aluSll:  aluRes = opA << shamt;
      aluSlt:  aluRes = {{(`CORE_XLEN-1){1'b0}}, ($signed(opA) < $signed(opB))};
      aluSltu: aluRes = {{(`CORE_XLEN-1){1'b0}}, (opA < opB)};
      aluXor:  aluRes = opA ^ opB;
      aluSrl:  aluRes = opA >> shamt;
      aluSra:  aluRes = $signed(opA) >>> shamt;
      aluOr:   aluRes = opA | opB;
      aluAnd:  aluRes = opA & opB;
      default: aluRes = exInstr.imm;   // pass-immediate for lui
    endcase
  end

  // result record, illegal ops carry zero data
  assign resValid = exValid;
  assign res = '{
    rd:      exInstr.rd,
    data:    exInstr.illegal ? '0 : aluRes,
    writeEn: exInstr.writeEn,
    illegal: exInstr.illegal
  };

  // stage has no clock of its own, checked once the inputs settle
  aluOpInRange: assert final (!exValid || (exInstr.aluOp inside {[aluAdd:aluPassImm]}))
    else $error("execute: aluOp %0d outside the operation set", exInstr.aluOp);

endmodule

/* instrDecoder.sv */
// decode stage that samples the instruction strobe and turns the word into a decoded record
`timescale 1ns/1ns
`include "core_config.svh"

module instrDecoder (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   instrValid,   // one-cycle strobe without handshake
  input  logic [31:0]            instr,
  output logic                   decValid,
  output corePkg::decodedInstr_t decInstr
);
  import corePkg::*;

  logic                  instrValidQ;
  logic [31:0]           instrQ;
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`CORE_XLEN-1:0] immI;
  logic [`CORE_XLEN-1:0] immU;
  aluOp_t                aluOp;
  logic                  immSel;
  logic                  legal;

  ////////////////////////////////////////////////////////////////////////////
  // decode register (edge 0)
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      instrValidQ <= 1'b0;
    end else begin
      instrValidQ <= instrValid;
    end
  end

  always_ff @(posedge clk) begin
    if (instrValid) begin
      instrQ <= instr;   // held through bubbles
    end
  end

  assign decValid = instrValidQ;

  ////////////////////////////////////////////////////////////////////////////
  // field decode
  ////////////////////////////////////////////////////////////////////////////

  assign opcode = instrQ[6:0];
  assign funct3 = instrQ[14:12];
  assign funct7 = instrQ[31:25];
  assign immI   = {{(`CORE_XLEN-12){instrQ[31]}}, instrQ[31:20]};
  assign immU   = {instrQ[31:12], 12'b0};   // lui form with low bits zero

  always_comb begin
    aluOp  = aluAdd;
    immSel = 1'b0;
    legal  = 1'b0;
    case (opcode)
      `CORE_OP_REG: begin
        // funct7 must be zero except 0100000 for sub and sra
        legal = (funct7 == 7'b0000000) ||
                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        case (funct3)
          3'b000:  aluOp = funct7[5] ? aluSub : aluAdd;
          3'b001:  aluOp = aluSll;
          3'b010:  aluOp = aluSlt;
          3'b011:  aluOp = aluSltu;
          3'b100:  aluOp = aluXor;
          3'b101:  aluOp = funct7[5] ? aluSra : aluSrl;
          3'b110:  aluOp = aluOr;
          default: aluOp = aluAnd;
        endcase
      end
      `CORE_OP_IMM: begin
        immSel = 1'b1;
        legal  = 1'b1;
        case (funct3)
          3'b000:  aluOp = aluAdd;   // addi has no subtract form
          3'b001: begin
            aluOp = aluSll;
            legal = (funct7 == 7'b0000000);   // shamt only in [24:20]
          end
          3'b010:  aluOp = aluSlt;
          3'b011:  aluOp = aluSltu;
          3'b100:  aluOp = aluXor;
          3'b101: begin
            aluOp = funct7[5] ? aluSra : aluSrl;
            legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
          3'b110:  aluOp = aluOr;
          default: aluOp = aluAnd;
        endcase
      end
      `CORE_OP_LUI: begin
        aluOp  = aluPassImm;
        immSel = 1'b1;
        legal  = 1'b1;
      end
      default: legal = 1'b0;   // retires as illegal without a write
    endcase
  end

  always_comb begin
    decInstr.rd      = instrQ[11:7];
    decInstr.rs1     = instrQ[19:15];
    decInstr.rs2     = instrQ[24:20];
    decInstr.imm     = (aluOp == aluPassImm) ? immU : immI;
    decInstr.immSel  = immSel;
    decInstr.aluOp   = aluOp;
    decInstr.writeEn = legal;
    decInstr.illegal = !legal;
  end

  // a valid record comes from a fully loaded instruction word
  noUnknownDecode: assert property (@(posedge clk) disable iff (!rstN)
    decValid |-> !$isunknown(instrQ))
    else $error("decoder: valid record from unknown instruction word %h", instrQ);

endmodule

/* stageReg.sv */
// pipeline boundary register, one valid bit plus a payload of any packed type
`timescale 1ns/1ns

module stageReg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstN,
  input  logic     inValid,
  input  payload_t inData,
  output logic     outValid,
  output payload_t outData
);

  // valid is control state
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid <= 1'b0;
    end else begin
      outValid <= inValid;
    end
  end

  // payload only moves with a valid beat
  always_ff @(posedge clk) begin
    if (inValid) begin
      outData <= inData;   // bubbles keep the old record
    end
  end

endmodule

/* vlog.f */
+incdir+.
corePkg.sv
stageReg.sv
instrDecoder.sv
execUnit.sv
writebackStage.sv
coreTop.sv
coreTb.sv

/* writebackStage.sv */
// writeback stage: register file with debug access, and the retire record for the outside
`timescale 1ns/1ns
`include "core_config.svh"

module writebackStage (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   resValid,
  input  corePkg::execResult_t   res,
  input  logic [`CORE_REGAW-1:0] rs1Addr,
  input  logic [`CORE_REGAW-1:0] rs2Addr,
  input  logic [`CORE_REGAW-1:0] debugRegAddr,
  input  logic [`CORE_XLEN-1:0]  debugRegWdata,
  input  logic                   debugRegWrite,
  output logic [`CORE_XLEN-1:0]  rs1Data,
  output logic [`CORE_XLEN-1:0]  rs2Data,
  output logic [`CORE_XLEN-1:0]  debugRegRdata,
  output logic                   retireValid,
  output logic [`CORE_REGAW-1:0] retireRd,
  output logic [`CORE_XLEN-1:0]  retireData,
  output logic                   retireIllegal
);
  import corePkg::*;

  logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
  logic                  pipeWrite;
  logic                  debugWrite;
  execResult_t           retireRec;

  ////////////////////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////////////////////

  // x0 is never written, so it stays at its reset value of zero
  assign pipeWrite  = resValid && res.writeEn && (res.rd != '0);
  assign debugWrite = debugRegWrite && (debugRegAddr != '0) && !pipeWrite;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `CORE_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (pipeWrite) begin
      regs[res.rd] <= res.data;   // edge 2
    end else if (debugWrite) begin
      regs[debugRegAddr] <= debugRegWdata;
    end
  end

  // combinational reads
  assign rs1Data       = regs[rs1Addr];
  assign rs2Data       = regs[rs2Addr];
  assign debugRegRdata = regs[debugRegAddr];

  // pipeline wins, the debug write of that cycle is dropped
  debugCollision: assert property (@(posedge clk) disable iff (!rstN)
    !(pipeWrite && debugRegWrite))
    else $warning("debug write to x%0d lost to pipeline write of x%0d",
                  debugRegAddr, res.rd);

  ////////////////////////////////////////////////////////////////////////////
  // retire record
  ////////////////////////////////////////////////////////////////////////////

  stageReg #(.payload_t(execResult_t)) u_retireReg (
    .clk,
    .rstN,
    .inValid  (resValid),
    .inData   (res),
    .outValid (retireValid),   // one cycle per finished instruction
    .outData  (retireRec)
  );

  assign retireRd      = retireRec.rd;
  assign retireData    = retireRec.data;      // x0 writes still report their value
  assign retireIllegal = retireRec.illegal;

endmodule
